// File: Makefile
# Verilator build of the plane subsystem testbench
VERILATOR ?= verilator
TOP       ?= tb_plane_subsystem
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SRCS    := $(wildcard rtl/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/ahb_bus_tasks.svh
/* single AHB-Lite transfers, each one followed by two IDLE cycles.
   call at the drive point just after a rising edge; every task returns at such a point */
`ifndef AHB_BUS_TASKS_SVH
`define AHB_BUS_TASKS_SVH

// park the bus, no transfer
task automatic bus_idle();
  HSEL   = 1'b0;
  HTRANS = IDLE;
  HWRITE = 1'b0;
endtask

task automatic next_drive_point();
  @(posedge HCLK);
  #DRIVE_DLY;  // inputs move just after the edge
endtask

task automatic single_write(input logic [REG_OFS_W-1:0] ofs,
                            input logic [AHB_DATA_W-1:0] data);
  HSEL   = 1'b1;  // address phase
  HTRANS = NONSEQ;
  HWRITE = 1'b1;
  HADDR  = AHB_ADDR_W'(ofs) << AHB_WORD_LSB;
  next_drive_point();
  bus_idle();
  HWDATA = data;  // data phase
  next_drive_point();  // register loads at this edge
  repeat (2) next_drive_point();  // idle gap, status catches up
endtask

task automatic single_read(input  logic [REG_OFS_W-1:0]  ofs,
                           output logic [AHB_DATA_W-1:0] data);
  HSEL   = 1'b1;
  HTRANS = NONSEQ;
  HWRITE = 1'b0;
  HADDR  = AHB_ADDR_W'(ofs) << AHB_WORD_LSB;
  next_drive_point();
  bus_idle();
  @(negedge HCLK);  // mid data phase, HRDATA settled
  data = HRDATA;
  next_drive_point();
  repeat (2) next_drive_point();
endtask

`endif

// File: bench/tb_plane_subsystem.sv
/* drives the plane subsystem over AHB-Lite, one transfer at a time with idle gaps.
   expected values come from a small reference model of the plane rules */
module tb_plane_subsystem;
  import ahb_pkg::*;
  import plane_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DLY    = 2;    // input skew after the rising edge
  localparam int RESET_CYCLES = 4;
  localparam int NUM_XFERS    = 175;  // planned bus transfers
  localparam int XFER_CYCLES  = 4;    // address, data, two idle
  localparam int MARGIN       = 64;
  localparam logic [REG_OFS_W-1:0] UNMAPPED_OFS = 6'h2a;
  localparam logic [31:0] SEED = 32'h818e_f630;

  logic                    HCLK;
  logic                    HRESETn;
  logic                    HSEL;
  logic [AHB_ADDR_W-1:0]   HADDR;
  htrans_t                 HTRANS;
  logic [AHB_SIZE_W-1:0]   HSIZE;
  logic [AHB_PROT_W-1:0]   HPROT;
  logic                    HWRITE;
  logic [AHB_DATA_W-1:0]   HWDATA;
  logic                    HREADY;
  logic                    HREADYOUT;
  logic [AHB_DATA_W-1:0]   HRDATA;
  logic                    HRESP;
  plane_status_t           status;

  // reference model, control mirror and plane
  logic                  m_update;
  logic                  m_create;
  logic                  m_hit;
  logic [COORD_W-1:0]    m_init_x;
  logic [COORD_W-1:0]    m_init_y;
  logic [COORD_W-1:0]    m_x;
  logic [COORD_W-1:0]    m_y;
  logic [ATTITUDE_W-1:0] m_att;
  logic                  m_live;

  plane_subsystem UUT (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HSIZE     (HSIZE),
    .HPROT     (HPROT),
    .HWRITE    (HWRITE),
    .HWDATA    (HWDATA),
    .HREADY    (HREADY),
    .HREADYOUT (HREADYOUT),
    .HRDATA    (HRDATA),
    .HRESP     (HRESP),
    .status    (status)
  );

  `include "ahb_bus_tasks.svh"

  initial HCLK = 1'b0;
  always #(CLK_PERIOD / 2) HCLK = ~HCLK;

  //------------------------------
  // model and checks
  //------------------------------
  task automatic model_write(input logic [REG_OFS_W-1:0] ofs, input logic [AHB_DATA_W-1:0] data);
    int ny;
    case (ofs)
      REG_UPDATE: begin
        if (data[0] && !m_update && m_live) begin  // rise moves a live plane
          ny = int'(m_y) + PLANE_STEP;
          m_y = ny[COORD_W-1:0];
          m_att = ATTITUDE_W'((int'(m_att) + 1) % ATTITUDE_FRAMES);
          if (ny >= int'(PLANE_Y_MAX)) begin
            m_live = 1'b0;  // bottom reached
          end
        end
        m_update = data[0];
      end
      REG_CREATE: begin
        if (data[0] && !m_create) begin
          m_x    = m_init_x;
          m_y    = m_init_y;
          m_att  = '0;
          m_live = 1'b1;
        end
        m_create = data[0];
      end
      REG_HIT: begin
        if (data[0] && !m_hit) begin
          m_live = 1'b0;  // position kept
        end
        m_hit = data[0];
      end
      REG_INIT_X: m_init_x = data[COORD_W-1:0];
      REG_INIT_Y: m_init_y = data[COORD_W-1:0];
      default: begin
        // read-only and unmapped, nothing stored
      end
    endcase
  endtask

  task automatic write_reg(input logic [REG_OFS_W-1:0] ofs, input logic [AHB_DATA_W-1:0] data);
    single_write(ofs, data);
    model_write(ofs, data);
  endtask

  task automatic check_reg(input string name, input logic [REG_OFS_W-1:0] ofs,
                           input logic [AHB_DATA_W-1:0] expected);
    logic [AHB_DATA_W-1:0] got;
    single_read(ofs, got);
    assert (got === expected) else begin
      $display("Error: %s HRDATA expected 0x%08h actual 0x%08h", name, expected, got);
      $display("*** FAILED ***");
      $fatal(1, "register read mismatch");
    end
  endtask

  task automatic check_ctrl();
    check_reg("REG_UPDATE", REG_UPDATE, AHB_DATA_W'(m_update));
    check_reg("REG_CREATE", REG_CREATE, AHB_DATA_W'(m_create));
    check_reg("REG_HIT", REG_HIT, AHB_DATA_W'(m_hit));
    check_reg("REG_INIT_X", REG_INIT_X, AHB_DATA_W'(m_init_x));
    check_reg("REG_INIT_Y", REG_INIT_Y, AHB_DATA_W'(m_init_y));
  endtask

  // display port, sampled between edges
  task automatic check_status_port();
    plane_status_t expected;
    expected = {m_x, m_y, m_att, m_live};
    assert (status === expected) else begin
      $display("Error: status expected 0x%07h actual 0x%07h", expected, status);
      $display("*** FAILED ***");
      $fatal(1, "status port mismatch");
    end
  endtask

  task automatic check_status();
    check_status_port();
    check_reg("REG_POS_X", REG_POS_X, AHB_DATA_W'(m_x));
    check_reg("REG_POS_Y", REG_POS_Y, AHB_DATA_W'(m_y));
    check_reg("REG_ATTITUDE", REG_ATTITUDE, AHB_DATA_W'(m_att));
    check_reg("REG_LIVE", REG_LIVE, AHB_DATA_W'(m_live));
  endtask

  task automatic update_pulse();
    write_reg(REG_UPDATE, 32'd0);
    write_reg(REG_UPDATE, 32'd1);  // one rise, one step
    check_status();
  endtask

  // slave must never stretch or error
  always @(negedge HCLK) begin
    assert (HREADYOUT === 1'b1 && HRESP === 1'b0) else begin
      $display("Error: HREADYOUT/HRESP expected 0x1/0x0 actual 0x%0h/0x%0h", HREADYOUT, HRESP);
      $display("*** FAILED ***");
      $fatal(1, "bus response check");
    end
  end

  // watchdog
  initial begin
    #((NUM_XFERS * XFER_CYCLES + RESET_CYCLES + MARGIN) * CLK_PERIOD);
    $display("test timed out before all bus transfers finished");
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

  //------------------------------
  // stimulus
  //------------------------------
  initial begin
    logic [COORD_W-1:0] rnd_x;
    logic [COORD_W-1:0] rnd_y;
    HRESETn = 1'b0;
    HSEL = 1'b0;
    HADDR = '0;
    HTRANS = IDLE;
    HSIZE = 3'b010;  // word, ignored by the slave
    HPROT = 4'b0011;
    HWRITE = 1'b0;
    HWDATA = '0;
    HREADY = 1'b1;  // single slave, bus always ready
    {m_update, m_create, m_hit, m_init_x, m_init_y} = '0;
    {m_x, m_y, m_att, m_live} = '0;
    void'($urandom(SEED));
    repeat (RESET_CYCLES) @(posedge HCLK);
    #DRIVE_DLY;
    HRESETn = 1'b1;

    check_ctrl();  // everything 0 out of reset
    check_status();
    check_reg("unmapped", UNMAPPED_OFS, '0);

    write_reg(REG_UPDATE, 32'hffff_ffff);  // rise while dead, no move
    write_reg(REG_HIT, 32'hffff_fffd);
    write_reg(REG_INIT_X, 32'h1234_56c3);
    write_reg(REG_INIT_Y, 32'hcafe_0a5e);
    check_ctrl();
    write_reg(REG_UPDATE, 32'hffff_fffe);
    write_reg(REG_HIT, 32'h8000_0000);
    check_ctrl();
    for (int ofs = int'(REG_POS_X); ofs <= int'(REG_LIVE); ofs++) begin
      write_reg(REG_OFS_W'(ofs), '1);  // read-only, dropped
    end
    write_reg(UNMAPPED_OFS, '1);
    check_reg("unmapped", UNMAPPED_OFS, '0);
    check_ctrl();
    check_status();

    // spawn at a random spot
    rnd_x = 8'($urandom);
    rnd_y = 8'($urandom % 100);
    write_reg(REG_INIT_X, AHB_DATA_W'(rnd_x));
    write_reg(REG_INIT_Y, AHB_DATA_W'(rnd_y));
    write_reg(REG_CREATE, 32'd1);
    check_status();
    check_reg("REG_CREATE", REG_CREATE, AHB_DATA_W'(m_create));
    write_reg(REG_INIT_X, AHB_DATA_W'(~rnd_x));
    write_reg(REG_CREATE, 32'd1);  // level held, no respawn
    check_status();

    repeat (6) update_pulse();  // attitude wraps past 3

    // start near the bottom
    write_reg(REG_CREATE, 32'd0);
    write_reg(REG_INIT_Y, AHB_DATA_W'(PLANE_Y_MAX - 8'd3));
    write_reg(REG_CREATE, 32'd1);
    check_status();
    repeat (4) update_pulse();  // dies on the third, fourth is ignored

    // hit, dead updates, respawn
    rnd_y = 8'($urandom % 100);
    write_reg(REG_INIT_Y, AHB_DATA_W'(rnd_y));
    write_reg(REG_CREATE, 32'd0);
    write_reg(REG_CREATE, 32'd1);
    check_status();
    update_pulse();
    write_reg(REG_HIT, 32'd0);
    write_reg(REG_HIT, 32'd1);
    check_status();
    repeat (2) update_pulse();
    write_reg(REG_CREATE, 32'd0);
    write_reg(REG_CREATE, 32'd1);
    check_status();

    // create and hit back to back, both orders
    write_reg(REG_HIT, 32'd0);
    write_reg(REG_CREATE, 32'd0);
    write_reg(REG_HIT, 32'd1);
    write_reg(REG_CREATE, 32'd1);
    check_status();
    write_reg(REG_HIT, 32'd0);
    write_reg(REG_CREATE, 32'd0);
    write_reg(REG_CREATE, 32'd1);
    write_reg(REG_HIT, 32'd1);
    check_status();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: build.f
+incdir+bench
rtl/ahb_pkg.sv
rtl/plane_pkg.sv
rtl/ahb_plane_interface.sv
rtl/enemy_plane_logic.sv
rtl/plane_subsystem.sv
bench/tb_plane_subsystem.sv

// File: rtl/ahb_pkg.sv
/* AHB-Lite bus types and widths shared by the slave, the top level and the bench.
   only single transfers are exercised; burst types decode but carry no extra meaning */
package ahb_pkg;

  //------------------------------
  // bus widths
  //------------------------------
  localparam int AHB_ADDR_W = 32;  // byte address
  localparam int AHB_DATA_W = 32;  // word data, read and write
  localparam int AHB_SIZE_W = 3;   // HSIZE, accepted and ignored
  localparam int AHB_PROT_W = 4;   // HPROT, accepted and ignored

  // word offset is taken from the byte address above bit 1
  localparam int AHB_WORD_LSB = 2;

  //------------------------------
  // transfer types
  //------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00,  // no transfer
    BUSY   = 2'b01,  // master pause inside a burst
    NONSEQ = 2'b10,  // first or single transfer
    SEQ    = 2'b11   // burst continuation
  } htrans_t;

  // fixed slave responses, no wait states and no errors
  localparam logic AHB_READY_OUT = 1'b1;
  localparam logic AHB_RESP_OKAY = 1'b0;

endpackage

// File: rtl/ahb_plane_interface.sv
/* always-ready AHB-Lite slave, single word registers only; HSIZE and HPROT are ignored.
   writes land at the end of the data phase, reads are combinational off the registered offset */
module ahb_plane_interface (
  input  logic                              HCLK,
  input  logic                              HRESETn,
  input  logic                              HSEL,
  input  logic [ahb_pkg::AHB_ADDR_W-1:0]    HADDR,
  input  ahb_pkg::htrans_t                  HTRANS,
  input  logic [ahb_pkg::AHB_SIZE_W-1:0]    HSIZE,   // ignored
  input  logic [ahb_pkg::AHB_PROT_W-1:0]    HPROT,   // ignored
  input  logic                              HWRITE,
  input  logic [ahb_pkg::AHB_DATA_W-1:0]    HWDATA,
  input  logic                              HREADY,
  output logic                              HREADYOUT,
  output logic [ahb_pkg::AHB_DATA_W-1:0]    HRDATA,
  output logic                              HRESP,
  output plane_pkg::plane_ctrl_t            ctrl,    // control levels to plane logic
  input  plane_pkg::plane_status_t          status   // fed back from plane logic
);
  import ahb_pkg::*;
  import plane_pkg::*;

  logic                 accept;  // valid transfer in address phase
  logic [REG_OFS_W-1:0] addr_q;  // word offset held for data phase
  logic                 wr_q;    // one cycle write strobe

  // never stretched, never errors
  assign HREADYOUT = AHB_READY_OUT;
  assign HRESP     = AHB_RESP_OKAY;

  // BUSY and IDLE are not transfers
  assign accept = HSEL && HREADY && (HTRANS == NONSEQ || HTRANS == SEQ);

  //------------------------------
  // address phase capture
  //------------------------------
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      addr_q <= '0;
      wr_q   <= 1'b0;
    end else begin
      if (accept) begin
        addr_q <= HADDR[AHB_WORD_LSB +: REG_OFS_W];  // hold offset for reads too
      end
      wr_q <= accept && HWRITE;  // strobe drops after one data phase
    end
  end

  //------------------------------
  // control registers
  //------------------------------
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      ctrl <= '0;
    end else if (wr_q) begin
      case (addr_q)
        REG_UPDATE: ctrl.update <= HWDATA[0];
        REG_CREATE: ctrl.create <= HWDATA[0];
        REG_HIT:    ctrl.hit    <= HWDATA[0];
        REG_INIT_X: ctrl.init_x <= HWDATA[COORD_W-1:0];
        REG_INIT_Y: ctrl.init_y <= HWDATA[COORD_W-1:0];
        default: begin
          // status and unmapped offsets, write dropped
        end
      endcase
    end
  end

  //------------------------------
  // read decoder
  //------------------------------
  always_comb begin
    HRDATA = '0;  // zero extend, unmapped reads 0
    case (addr_q)
      REG_UPDATE:   HRDATA[0] = ctrl.update;
      REG_CREATE:   HRDATA[0] = ctrl.create;
      REG_HIT:      HRDATA[0] = ctrl.hit;
      REG_INIT_X:   HRDATA[COORD_W-1:0] = ctrl.init_x;
      REG_INIT_Y:   HRDATA[COORD_W-1:0] = ctrl.init_y;
      REG_POS_X:    HRDATA[COORD_W-1:0] = status.pos_x;
      REG_POS_Y:    HRDATA[COORD_W-1:0] = status.pos_y;
      REG_ATTITUDE: HRDATA[ATTITUDE_W-1:0] = status.attitude;
      REG_LIVE:     HRDATA[0] = status.live;
      default:      HRDATA = '0;
    endcase
  end

endmodule

// File: rtl/enemy_plane_logic.sv
/* single enemy plane, acting on rising edges of the CPU written control levels.
   priority create > hit > update; status follows one cycle after a control register changes */
module enemy_plane_logic (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  plane_pkg::plane_ctrl_t   ctrl,    // levels from the slave registers
  output plane_pkg::plane_status_t status   // position, frame and live
);
  import plane_pkg::*;

  logic                  update_q;    // previous update level
  logic                  create_q;    // previous create level
  logic                  hit_q;       // previous hit level
  logic                  update_rise;
  logic                  create_rise;
  logic                  hit_rise;

  plane_state_e          state_q;
  logic [COORD_W-1:0]    pos_x_q;
  logic [COORD_W-1:0]    pos_y_q;
  logic [ATTITUDE_W-1:0] attitude_q;

  logic [COORD_W:0]      next_y;       // one extra bit so a wrap still counts as bottom
  logic [ATTITUDE_W-1:0] next_attitude;

  //------------------------------
  // edge detection
  //------------------------------
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      update_q <= 1'b0;
      create_q <= 1'b0;
      hit_q    <= 1'b0;
    end else begin
      update_q <= ctrl.update;  // sampled every cycle
      create_q <= ctrl.create;
      hit_q    <= ctrl.hit;
    end
  end

  assign update_rise = ctrl.update && !update_q;
  assign create_rise = ctrl.create && !create_q;
  assign hit_rise    = ctrl.hit && !hit_q;

  // movement step and frame wrap
  assign next_y = {1'b0, pos_y_q} + (COORD_W + 1)'(PLANE_STEP);
  assign next_attitude = (attitude_q == ATTITUDE_W'(ATTITUDE_FRAMES - 1)) ?
                         '0 : attitude_q + 1'b1;

  //------------------------------
  // plane state
  //------------------------------
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q    <= DEAD;
      pos_x_q    <= '0;
      pos_y_q    <= '0;
      attitude_q <= '0;
    end else if (create_rise) begin
      // spawn, also over a live plane
      state_q    <= FLYING;
      pos_x_q    <= ctrl.init_x;
      pos_y_q    <= ctrl.init_y;
      attitude_q <= '0;
    end else if (hit_rise) begin
      state_q <= DEAD;  // position kept where it was shot
    end else if (update_rise && state_q == FLYING) begin
      pos_y_q    <= next_y[COORD_W-1:0];
      attitude_q <= next_attitude;
      if (next_y >= {1'b0, PLANE_Y_MAX}) begin
        state_q <= DEAD;  // left the screen
      end
    end
  end

  // status straight from the registers
  assign status.pos_x    = pos_x_q;
  assign status.pos_y    = pos_y_q;
  assign status.attitude = attitude_q;
  assign status.live     = (state_q == FLYING);

endmodule

// File: rtl/plane_pkg.sv
/* register map, plane constants and the control and status structs of one enemy plane.
   coordinates are 8 bit screen pixels, the plane moves downward only */
package plane_pkg;

  //------------------------------
  // register map
  //------------------------------
  localparam int REG_OFS_W = 6;  // word offset = HADDR[7:2]

  typedef enum logic [REG_OFS_W-1:0] {
    REG_UPDATE   = 6'd0,  // rw, bit 0, movement tick
    REG_CREATE   = 6'd1,  // rw, bit 0, spawn on rise
    REG_HIT      = 6'd2,  // rw, bit 0, kill on rise
    REG_INIT_X   = 6'd3,  // rw, spawn x
    REG_INIT_Y   = 6'd4,  // rw, spawn y
    REG_POS_X    = 6'd5,  // ro
    REG_POS_Y    = 6'd6,  // ro
    REG_ATTITUDE = 6'd7,  // ro, animation frame
    REG_LIVE     = 6'd8   // ro
  } plane_reg_e;

  //------------------------------
  // plane constants
  //------------------------------
  localparam int COORD_W         = 8;
  localparam int ATTITUDE_W      = 8;       // frame counter as seen on the bus
  localparam int PLANE_STEP      = 1;       // pixels down per update
  localparam logic [COORD_W-1:0] PLANE_Y_MAX = 8'd160;  // bottom of screen
  localparam int ATTITUDE_FRAMES = 4;       // frames 0..3 then wrap

  typedef enum logic {
    DEAD   = 1'b0,
    FLYING = 1'b1
  } plane_state_e;

  // CPU written levels, slave -> logic (19 bits)
  typedef struct packed {
    logic               update;
    logic               create;
    logic               hit;
    logic [COORD_W-1:0] init_x;
    logic [COORD_W-1:0] init_y;
  } plane_ctrl_t;

  // plane state seen by CPU and display, logic -> slave (25 bits)
  typedef struct packed {
    logic [COORD_W-1:0]    pos_x;
    logic [COORD_W-1:0]    pos_y;
    logic [ATTITUDE_W-1:0] attitude;
    logic                  live;
  } plane_status_t;

endpackage

// File: rtl/plane_subsystem.sv
/* one enemy plane behind an AHB-Lite slave port; status is also brought out for a display */
module plane_subsystem (
  input  logic                              HCLK,
  input  logic                              HRESETn,
  input  logic                              HSEL,
  input  logic [ahb_pkg::AHB_ADDR_W-1:0]    HADDR,
  input  ahb_pkg::htrans_t                  HTRANS,
  input  logic [ahb_pkg::AHB_SIZE_W-1:0]    HSIZE,
  input  logic [ahb_pkg::AHB_PROT_W-1:0]    HPROT,
  input  logic                              HWRITE,
  input  logic [ahb_pkg::AHB_DATA_W-1:0]    HWDATA,
  input  logic                              HREADY,
  output logic                              HREADYOUT,
  output logic [ahb_pkg::AHB_DATA_W-1:0]    HRDATA,
  output logic                              HRESP,
  output plane_pkg::plane_status_t          status
);
  import plane_pkg::*;

  plane_ctrl_t ctrl;  // register levels, slave -> logic

  ahb_plane_interface u_ahb_plane_interface (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HSIZE     (HSIZE),
    .HPROT     (HPROT),
    .HWRITE    (HWRITE),
    .HWDATA    (HWDATA),
    .HREADY    (HREADY),
    .HREADYOUT (HREADYOUT),
    .HRDATA    (HRDATA),
    .HRESP     (HRESP),
    .ctrl      (ctrl),
    .status    (status)  // read back over the bus
  );

  enemy_plane_logic u_enemy_plane_logic (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .ctrl    (ctrl),
    .status  (status)
  );

endmodule
